//--- Makefile
VERILATOR ?= verilator
TOP       ?= mips_pipeline_tb
FILELIST  ?= mips_pipeline.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/decode_stage.sv
`include "mips_consts.svh"

module decode_stage (
	input  logic                     clk,
	input  logic                     reset_i,
	input  mips_pipe_pkg::word_t     if_instr_i,
	input  mips_pipe_pkg::word_t     if_pc_plus4_i,
	input  logic                     wb_we_i,
	input  mips_pipe_pkg::reg_idx_t  wb_addr_i,
	input  mips_pipe_pkg::word_t     wb_data_i,
	output logic                     id_reg_write_o,
	output logic                     id_mem_read_o,
	output logic                     id_mem_write_o,
	output logic                     id_mem_to_reg_o,
	output logic                     id_alu_src_o,
	output logic                     id_branch_eq_o,
	output logic                     id_branch_ne_o,
	output mips_pipe_pkg::alu_op_e   id_alu_op_o,
	output mips_pipe_pkg::word_t     id_rs_data_o,
	output mips_pipe_pkg::word_t     id_rt_data_o,
	output mips_pipe_pkg::word_t     id_imm_o,
	output mips_pipe_pkg::word_t     id_pc_plus4_o,
	output mips_pipe_pkg::reg_idx_t  id_rs_o,
	output mips_pipe_pkg::reg_idx_t  id_rt_o,
	output mips_pipe_pkg::reg_idx_t  id_dest_o,
	output mips_isa_pkg::funct_e     id_funct_o
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	opcode_e  opcode;
	funct_e   funct;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	logic     reg_write, mem_read, mem_write, mem_to_reg;
	logic     alu_src, reg_dst, branch_eq, branch_ne, zero_ext;
	alu_op_e  alu_op;
	word_t    imm;
	word_t    rs_data;
	word_t    rt_data;
	word_t    regs [`MIPS_REG_COUNT];   // register file

	assign opcode = opcode_e'(if_instr_i[31:26]);
	assign rs     = if_instr_i[25:21];
	assign rt     = if_instr_i[20:16];
	assign rd     = if_instr_i[15:11];
	assign funct  = funct_e'(if_instr_i[5:0]);

	// main control
	always_comb begin
		{reg_write, mem_read, mem_write, mem_to_reg} = '0;
		{alu_src, reg_dst, branch_eq, branch_ne, zero_ext} = '0;
		alu_op = aop_add;
		case (opcode)
			op_rtype: begin
				// nop and unsupported functs write nothing
				if (funct inside {fn_add, fn_sub, fn_and, fn_or, fn_nor}) begin
					reg_write = 1'b1;
					reg_dst   = 1'b1;             // dest is rd
					alu_op    = aop_funct;
				end
			end
			op_addi: {reg_write, alu_src} = 2'b11;
			op_ori: begin
				{reg_write, alu_src, zero_ext} = 3'b111;
				alu_op = aop_or;
			end
			op_lw:  {reg_write, mem_read, mem_to_reg, alu_src} = 4'b1111;
			op_sw:  {mem_write, alu_src} = 2'b11;   // address = rs + imm
			op_beq: begin
				branch_eq = 1'b1;
				alu_op    = aop_sub;          // zero flag tells equal
			end
			op_bne: begin
				branch_ne = 1'b1;
				alu_op    = aop_sub;
			end
			default: ;                       // unknown opcode, bubble
		endcase
	end

	assign imm = zero_ext ? {16'b0, if_instr_i[15:0]} : {{16{if_instr_i[15]}}, if_instr_i[15:0]};

	// r0 never written
	always_ff @(posedge clk) begin
		if (wb_we_i && wb_addr_i != '0) begin
			regs[wb_addr_i] <= wb_data_i;
		end
	end

	// reads see a same cycle write, r0 pinned to zero
	assign rs_data = (rs == '0) ? '0 : (wb_we_i && wb_addr_i == rs) ? wb_data_i : regs[rs];
	assign rt_data = (rt == '0) ? '0 : (wb_we_i && wb_addr_i == rt) ? wb_data_i : regs[rt];

	// id/ex
	always_ff @(posedge clk) begin
		if (reset_i) begin
			{id_reg_write_o, id_mem_read_o, id_mem_write_o, id_mem_to_reg_o} <= '0;
			{id_alu_src_o, id_branch_eq_o, id_branch_ne_o} <= '0;
			id_alu_op_o   <= aop_add;
			id_rs_data_o  <= '0;
			id_rt_data_o  <= '0;
			id_imm_o      <= '0;
			id_pc_plus4_o <= '0;
			id_rs_o       <= '0;
			id_rt_o       <= '0;
			id_dest_o     <= '0;
			id_funct_o    <= funct_e'(6'd0);
		end else begin
			{id_reg_write_o, id_mem_read_o, id_mem_write_o, id_mem_to_reg_o} <=
				{reg_write, mem_read, mem_write, mem_to_reg};
			{id_alu_src_o, id_branch_eq_o, id_branch_ne_o} <= {alu_src, branch_eq, branch_ne};
			id_alu_op_o   <= alu_op;
			id_rs_data_o  <= rs_data;
			id_rt_data_o  <= rt_data;
			id_imm_o      <= imm;
			id_pc_plus4_o <= if_pc_plus4_i;
			id_rs_o       <= rs;
			id_rt_o       <= rt;
			id_dest_o     <= reg_dst ? rd : rt;   // rd for r-type, rt for i-type
			id_funct_o    <= funct;
		end
	end

endmodule

//--- logic/execute_stage.sv
`include "mips_consts.svh"

module execute_stage (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     id_reg_write_i,
	input  logic                     id_mem_read_i,
	input  logic                     id_mem_write_i,
	input  logic                     id_mem_to_reg_i,
	input  logic                     id_alu_src_i,
	input  logic                     id_branch_eq_i,
	input  logic                     id_branch_ne_i,
	input  mips_pipe_pkg::alu_op_e   id_alu_op_i,
	input  mips_pipe_pkg::word_t     id_rs_data_i,
	input  mips_pipe_pkg::word_t     id_rt_data_i,
	input  mips_pipe_pkg::word_t     id_imm_i,
	input  mips_pipe_pkg::word_t     id_pc_plus4_i,
	input  mips_pipe_pkg::reg_idx_t  id_rs_i,
	input  mips_pipe_pkg::reg_idx_t  id_rt_i,
	input  mips_pipe_pkg::reg_idx_t  id_dest_i,
	input  mips_isa_pkg::funct_e     id_funct_i,
	input  logic                     mem_reg_write_i,
	input  mips_pipe_pkg::reg_idx_t  mem_dest_i,
	input  logic                     wb_we_i,
	input  mips_pipe_pkg::reg_idx_t  wb_addr_i,
	input  mips_pipe_pkg::word_t     wb_data_i,
	output mips_pipe_pkg::word_t     ex_result_o,
	output logic                     ex_zero_o,
	output mips_pipe_pkg::word_t     ex_store_data_o,
	output mips_pipe_pkg::word_t     ex_branch_target_o,
	output mips_pipe_pkg::reg_idx_t  ex_dest_o,
	output logic                     ex_reg_write_o,
	output logic                     ex_mem_read_o,
	output logic                     ex_mem_write_o,
	output logic                     ex_mem_to_reg_o,
	output logic                     ex_branch_eq_o,
	output logic                     ex_branch_ne_o
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	alu_ctl_e alu_ctl;
	word_t    op_a;
	word_t    rt_fwd;       // forwarded rt doubles as store data
	word_t    op_b;
	word_t    alu_res;

	// ex/mem is the younger producer so it wins over mem/wb
	function automatic fwd_sel_e pick_src(reg_idx_t src, logic mem_we, reg_idx_t mem_dst,
			logic wb_we, reg_idx_t wb_dst);
		if (mem_we && mem_dst != '0 && mem_dst == src)
			return fwd_exmem;
		if (wb_we && wb_dst != '0 && wb_dst == src)
			return fwd_wb;
		return fwd_reg;
	endfunction

	function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t wb_val,
			word_t mem_val);
		case (sel)
			fwd_exmem: return mem_val;
			fwd_wb:    return wb_val;
			default:   return reg_val;
		endcase
	endfunction

	assign fwd_a  = pick_src(id_rs_i, mem_reg_write_i, mem_dest_i, wb_we_i, wb_addr_i);
	assign fwd_b  = pick_src(id_rt_i, mem_reg_write_i, mem_dest_i, wb_we_i, wb_addr_i);
	assign op_a   = fwd_mux(fwd_a, id_rs_data_i, wb_data_i, ex_result_o);
	assign rt_fwd = fwd_mux(fwd_b, id_rt_data_i, wb_data_i, ex_result_o);
	assign op_b   = id_alu_src_i ? id_imm_i : rt_fwd;

	// alu control
	always_comb begin
		case (id_alu_op_i)
			aop_sub: alu_ctl = alu_sub;
			aop_or:  alu_ctl = alu_or;
			aop_funct: begin
				case (id_funct_i)
					fn_sub:  alu_ctl = alu_sub;
					fn_and:  alu_ctl = alu_and;
					fn_or:   alu_ctl = alu_or;
					fn_nor:  alu_ctl = alu_nor;
					default: alu_ctl = alu_add;
				endcase
			end
			default: alu_ctl = alu_add;
		endcase
	end

	always_comb begin
		case (alu_ctl)
			alu_and: alu_res = op_a & op_b;
			alu_or:  alu_res = op_a | op_b;
			alu_sub: alu_res = op_a - op_b;
			alu_nor: alu_res = ~(op_a | op_b);
			default: alu_res = op_a + op_b;
		endcase
	end

	// ex/mem
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_result_o        <= '0;
			ex_zero_o          <= 1'b0;
			ex_store_data_o    <= '0;
			ex_branch_target_o <= '0;
			ex_dest_o          <= '0;
			{ex_reg_write_o, ex_mem_read_o, ex_mem_write_o} <= '0;
			{ex_mem_to_reg_o, ex_branch_eq_o, ex_branch_ne_o} <= '0;
		end else begin
			ex_result_o        <= alu_res;
			ex_zero_o          <= (alu_res == '0);
			ex_store_data_o    <= rt_fwd;
			ex_branch_target_o <= id_pc_plus4_i + {id_imm_i[`MIPS_WORD_W-3:0], 2'b00};
			ex_dest_o          <= id_dest_i;
			{ex_reg_write_o, ex_mem_read_o, ex_mem_write_o} <=
				{id_reg_write_i, id_mem_read_i, id_mem_write_i};
			{ex_mem_to_reg_o, ex_branch_eq_o, ex_branch_ne_o} <=
				{id_mem_to_reg_i, id_branch_eq_i, id_branch_ne_i};
		end
	end

endmodule

//--- logic/fetch_stage.sv
`include "mips_consts.svh"

module fetch_stage (
	input  logic                         clk,
	input  logic                         reset_i,
	input  logic                         imem_we_i,
	input  logic [`MIPS_IMEM_ADDR_W-1:0] imem_addr_i,
	input  mips_pipe_pkg::word_t         imem_data_i,
	input  logic                         branch_taken_i,
	input  mips_pipe_pkg::word_t         branch_target_i,
	output mips_pipe_pkg::word_t         if_instr_o,
	output mips_pipe_pkg::word_t         if_pc_plus4_o
);
	import mips_pipe_pkg::*;

	word_t pc_q;                          // address being fetched
	word_t pc_plus4;
	word_t fetch_word;
	word_t imem [`MIPS_IMEM_DEPTH];       // program store

	assign pc_plus4   = pc_q + 32'd4;
	assign fetch_word = imem[pc_q[`MIPS_IMEM_ADDR_W+1:2]];   // byte pc to word index

	// program load port, only honoured while the core sits in reset
	always_ff @(posedge clk) begin
		if (reset_i && imem_we_i) begin
			imem[imem_addr_i] <= imem_data_i;
		end
	end

	// pc and if/id
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q          <= `MIPS_RESET_PC;
			if_instr_o    <= '0;          // all zero word decodes as a bubble
			if_pc_plus4_o <= '0;
		end else begin
			// branch redirect comes from ex/mem, three slots already in flight
			pc_q          <= branch_taken_i ? branch_target_i : pc_plus4;
			if_instr_o    <= fetch_word;
			if_pc_plus4_o <= pc_plus4;
		end
	end

endmodule

//--- logic/memory_stage.sv
`include "mips_consts.svh"

module memory_stage (
	input  logic                     clk,
	input  logic                     reset_i,
	input  mips_pipe_pkg::word_t     ex_result_i,
	input  logic                     ex_zero_i,
	input  mips_pipe_pkg::word_t     ex_store_data_i,
	input  mips_pipe_pkg::word_t     ex_branch_target_i,
	input  mips_pipe_pkg::reg_idx_t  ex_dest_i,
	input  logic                     ex_reg_write_i,
	input  logic                     ex_mem_read_i,
	input  logic                     ex_mem_write_i,
	input  logic                     ex_mem_to_reg_i,
	input  logic                     ex_branch_eq_i,
	input  logic                     ex_branch_ne_i,
	output logic                     branch_taken_o,
	output mips_pipe_pkg::word_t     branch_target_o,
	output logic                     wb_we_o,
	output mips_pipe_pkg::reg_idx_t  wb_addr_o,
	output mips_pipe_pkg::word_t     wb_data_o
);
	import mips_pipe_pkg::*;

	logic [`MIPS_DMEM_ADDR_W-1:0] dm_addr;
	word_t    load_data;
	word_t    dmem [`MIPS_DMEM_DEPTH];   // data store
	word_t    wb_load_q;
	word_t    wb_result_q;
	reg_idx_t wb_dest_q;
	logic     wb_mem_to_reg_q;
	logic     wb_reg_write_q;

	assign dm_addr   = ex_result_i[`MIPS_DMEM_ADDR_W+1:2];   // word index of byte address
	assign load_data = ex_mem_read_i ? dmem[dm_addr] : '0;

	always_ff @(posedge clk) begin
		if (ex_mem_write_i) begin
			dmem[dm_addr] <= ex_store_data_i;
		end
	end

	// resolved here, fetch picks it up on the next edge
	assign branch_taken_o  = (ex_branch_eq_i & ex_zero_i) | (ex_branch_ne_i & ~ex_zero_i);
	assign branch_target_o = ex_branch_target_i;

	// mem/wb
	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_load_q       <= '0;
			wb_result_q     <= '0;
			wb_dest_q       <= '0;
			wb_mem_to_reg_q <= 1'b0;
			wb_reg_write_q  <= 1'b0;
		end else begin
			wb_load_q       <= load_data;
			wb_result_q     <= ex_result_i;
			wb_dest_q       <= ex_dest_i;
			wb_mem_to_reg_q <= ex_mem_to_reg_i;
			wb_reg_write_q  <= ex_reg_write_i;
		end
	end

	assign wb_we_o   = wb_reg_write_q;
	assign wb_addr_o = wb_dest_q;
	assign wb_data_o = wb_mem_to_reg_q ? wb_load_q : wb_result_q;   // lw vs alu

endmodule

//--- logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath widths
`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_REG_COUNT   32   // r0..r31, r0 reads as zero

// harvard memories, word addressed
`define MIPS_IMEM_DEPTH  256
`define MIPS_IMEM_ADDR_W 8
`define MIPS_DMEM_DEPTH  256
`define MIPS_DMEM_ADDR_W 8

// first fetch after reset
`define MIPS_RESET_PC    32'h0000_0000

`endif

//--- logic/mips_isa_pkg.sv
package mips_isa_pkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,   // alu op picked by funct
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,   // sign extended imm
		op_ori   = 6'h0d,   // zero extended imm
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// funct field of r-type, instr[5:0]
	// shifts and jr are not decoded, they end up as bubbles
	typedef enum logic [5:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_nor = 6'h27
	} funct_e;

endpackage

//--- logic/mips_pipe_pkg.sv
`include "mips_consts.svh"

package mips_pipe_pkg;

	typedef logic [`MIPS_WORD_W-1:0]     word_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_idx_t;

	// class handed from main decode to alu control
	typedef enum logic [1:0] {
		aop_add   = 2'b00,   // lw, sw, addi
		aop_sub   = 2'b01,   // beq, bne compare
		aop_or    = 2'b10,   // ori
		aop_funct = 2'b11    // r-type, look at funct
	} alu_op_e;

	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_nor = 3'b100,
		alu_sub = 3'b110
	} alu_ctl_e;

	// operand source for the alu inputs
	typedef enum logic [1:0] {
		fwd_reg   = 2'b00,   // value read in decode
		fwd_wb    = 2'b01,   // mem/wb write-back data
		fwd_exmem = 2'b10    // ex/mem alu result
	} fwd_sel_e;

endpackage

//--- logic/mips_pipeline.sv
`include "mips_consts.svh"

module mips_pipeline (
	input  logic                         clk,
	input  logic                         reset_i,
	input  logic                         imem_we_i,
	input  logic [`MIPS_IMEM_ADDR_W-1:0] imem_addr_i,
	input  mips_pipe_pkg::word_t         imem_data_i,
	output logic                         wb_we_o,
	output mips_pipe_pkg::reg_idx_t      wb_addr_o,
	output mips_pipe_pkg::word_t         wb_data_o
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	// if/id
	word_t    if_instr, if_pc_plus4;
	// id/ex
	logic     id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg;
	logic     id_alu_src, id_branch_eq, id_branch_ne;
	alu_op_e  id_alu_op;
	word_t    id_rs_data, id_rt_data, id_imm, id_pc_plus4;
	reg_idx_t id_rs, id_rt, id_dest;
	funct_e   id_funct;
	// ex/mem
	word_t    ex_result, ex_store_data, ex_branch_target;
	logic     ex_zero, ex_reg_write, ex_mem_read, ex_mem_write;
	logic     ex_mem_to_reg, ex_branch_eq, ex_branch_ne;
	reg_idx_t ex_dest;
	// redirect back to fetch
	logic     branch_taken;
	word_t    branch_target;

	fetch_stage u_fetch (
		.clk, .reset_i, .imem_we_i, .imem_addr_i, .imem_data_i,
		.branch_taken_i(branch_taken), .branch_target_i(branch_target),
		.if_instr_o(if_instr), .if_pc_plus4_o(if_pc_plus4)
	);

	// write-back port feeds the register file
	decode_stage u_decode (
		.clk, .reset_i, .if_instr_i(if_instr), .if_pc_plus4_i(if_pc_plus4),
		.wb_we_i(wb_we_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
		.id_reg_write_o(id_reg_write), .id_mem_read_o(id_mem_read),
		.id_mem_write_o(id_mem_write), .id_mem_to_reg_o(id_mem_to_reg),
		.id_alu_src_o(id_alu_src), .id_branch_eq_o(id_branch_eq),
		.id_branch_ne_o(id_branch_ne), .id_alu_op_o(id_alu_op),
		.id_rs_data_o(id_rs_data), .id_rt_data_o(id_rt_data), .id_imm_o(id_imm),
		.id_pc_plus4_o(id_pc_plus4), .id_rs_o(id_rs), .id_rt_o(id_rt),
		.id_dest_o(id_dest), .id_funct_o(id_funct)
	);

	// ex/mem and mem/wb destinations loop back for forwarding
	execute_stage u_execute (
		.clk, .reset_i,
		.id_reg_write_i(id_reg_write), .id_mem_read_i(id_mem_read),
		.id_mem_write_i(id_mem_write), .id_mem_to_reg_i(id_mem_to_reg),
		.id_alu_src_i(id_alu_src), .id_branch_eq_i(id_branch_eq),
		.id_branch_ne_i(id_branch_ne), .id_alu_op_i(id_alu_op),
		.id_rs_data_i(id_rs_data), .id_rt_data_i(id_rt_data), .id_imm_i(id_imm),
		.id_pc_plus4_i(id_pc_plus4), .id_rs_i(id_rs), .id_rt_i(id_rt),
		.id_dest_i(id_dest), .id_funct_i(id_funct),
		.mem_reg_write_i(ex_reg_write), .mem_dest_i(ex_dest),
		.wb_we_i(wb_we_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
		.ex_result_o(ex_result), .ex_zero_o(ex_zero), .ex_store_data_o(ex_store_data),
		.ex_branch_target_o(ex_branch_target), .ex_dest_o(ex_dest),
		.ex_reg_write_o(ex_reg_write), .ex_mem_read_o(ex_mem_read),
		.ex_mem_write_o(ex_mem_write), .ex_mem_to_reg_o(ex_mem_to_reg),
		.ex_branch_eq_o(ex_branch_eq), .ex_branch_ne_o(ex_branch_ne)
	);

	memory_stage u_memory (
		.clk, .reset_i,
		.ex_result_i(ex_result), .ex_zero_i(ex_zero), .ex_store_data_i(ex_store_data),
		.ex_branch_target_i(ex_branch_target), .ex_dest_i(ex_dest),
		.ex_reg_write_i(ex_reg_write), .ex_mem_read_i(ex_mem_read),
		.ex_mem_write_i(ex_mem_write), .ex_mem_to_reg_i(ex_mem_to_reg),
		.ex_branch_eq_i(ex_branch_eq), .ex_branch_ne_i(ex_branch_ne),
		.branch_taken_o(branch_taken), .branch_target_o(branch_target),
		.wb_we_o, .wb_addr_o, .wb_data_o
	);

endmodule

//--- mips_pipeline.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_pipeline.sv
test/tb_clock_gen.sv
test/mips_pipeline_properties.sv
test/mips_pipeline_tb.sv

//--- test/mips_pipeline_properties.sv
module mips_pipeline_properties (
	input logic                 clk,
	input logic                 reset_i,
	input logic                 imem_we_i,
	input logic                 wb_we_o,
	input mips_pipe_pkg::word_t wb_data_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// mem/wb cleared after the first reset edge
	wb_quiet_in_reset: assert property (
		@(posedge clk) reset_i && $past(reset_i) |-> !wb_we_o
	) else $error("write-back strobe high while reset is held");

	// retired data must be fully known
	wb_data_known: assert property (
		@(posedge clk) disable iff (reset_i) wb_we_o |-> !$isunknown(wb_data_o)
	) else $error("write-back data has unknown bits");

	// program load only while the core sits in reset
	load_only_in_reset: assert property (
		@(posedge clk) imem_we_i |-> reset_i
	) else $error("program memory written outside reset");

endmodule

//--- test/mips_pipeline_tb.sv
`include "mips_consts.svh"

module mips_pipeline_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	localparam int IMEM_AW        = `MIPS_IMEM_ADDR_W;
	localparam int RESET_CYCLES   = 16;
	localparam int DRIVE_DELAY    = 1;    // ns after the rising edge
	localparam int MAX_PROG_WORDS = 16;
	localparam int RUN_SLACK      = 8;    // fetch to write-back is 4 cycles
	localparam int PAD_WORDS      = RUN_SLACK + 4;   // nops past the program
	localparam int NUM_TESTS      = 5;
	localparam int TEST_CYCLES    = (MAX_PROG_WORDS + PAD_WORDS + 1) +
		(MAX_PROG_WORDS + RUN_SLACK);
	localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 100;

	logic               clk;
	logic               reset_i;
	logic               imem_we_i;
	logic [IMEM_AW-1:0] imem_addr_i;
	word_t              imem_data_i;
	logic               wb_we_o;
	reg_idx_t           wb_addr_o;
	word_t              wb_data_o;

	word_t    prog_q[$];      // program of the current test
	reg_idx_t exp_idx_q[$];   // expected write-backs in order
	word_t    exp_val_q[$];
	reg_idx_t got_idx_q[$];   // observed write-backs
	word_t    got_val_q[$];
	int       cycle_count = 0;
	integer   seed = 94135;

	tb_clock_gen u_clock_gen (.clk_o(clk));

	mips_pipeline u_mips_pipeline (
		.clk, .reset_i, .imem_we_i, .imem_addr_i, .imem_data_i,
		.wb_we_o, .wb_addr_o, .wb_data_o
	);

	bind mips_pipeline mips_pipeline_properties u_properties (
		.clk, .reset_i, .imem_we_i, .wb_we_o, .wb_data_o
	);

	task automatic stop_on_error();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_reg_idx(string sig, string where, reg_idx_t got, reg_idx_t exp);
		if (got !== exp) begin
			$display("mismatch %s (%s): got 0x%02h expected 0x%02h", sig, where, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_word(string sig, string where, word_t got, word_t exp);
		if (got !== exp) begin
			$display("mismatch %s (%s): got 0x%08h expected 0x%08h", sig, where, got, exp);
			stop_on_error();
		end
	endtask

	task automatic next_drive_point();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	function automatic word_t encode_rtype(funct_e fn, int rd, int rs, int rt);
		return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t encode_itype(opcode_e op, int rt, int rs, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	task automatic expect_wb(int idx, word_t val);
		exp_idx_q.push_back(5'(idx));
		exp_val_q.push_back(val);
	endtask

	// reset held while the program goes in and for at least RESET_CYCLES edges
	task automatic load_and_reset();
		int n;
		int held;
		n = prog_q.size() + PAD_WORDS;
		next_drive_point();
		reset_i = 1'b1;
		for (int i = 0; i < n; i++) begin
			imem_we_i   = 1'b1;
			imem_addr_i = IMEM_AW'(i);
			imem_data_i = (i < prog_q.size()) ? prog_q[i] : 32'h0;   // nop pad
			next_drive_point();
		end
		imem_we_i = 1'b0;
		held = n;
		while (held < RESET_CYCLES) begin
			next_drive_point();
			held++;
		end
		reset_i = 1'b0;
	endtask

	task automatic run_program(string name);
		int    limit;
		int    cycles;
		string tag;
		load_and_reset();
		got_idx_q.delete();
		got_val_q.delete();
		limit  = prog_q.size() + RUN_SLACK;
		cycles = 0;
		while (got_idx_q.size() < exp_idx_q.size() && cycles < limit) begin
			@(negedge clk);   // outputs settled mid cycle
			if (wb_we_o) begin
				got_idx_q.push_back(wb_addr_o);
				got_val_q.push_back(wb_data_o);
			end
			cycles++;
		end
		if (got_idx_q.size() < exp_idx_q.size()) begin
			$display("%s: too few write-backs, expected %0d but saw %0d", name,
				exp_idx_q.size(), got_idx_q.size());
			stop_on_error();
		end
		for (int i = 0; i < exp_idx_q.size(); i++) begin
			tag = $sformatf("%s #%0d", name, i);
			compare_reg_idx("wb_addr_o", tag, got_idx_q[i], exp_idx_q[i]);
			compare_word("wb_data_o", tag, got_val_q[i], exp_val_q[i]);
		end
		prog_q.delete();
		exp_idx_q.delete();
		exp_val_q.delete();
	endtask

	// back to back dependents through ex/mem and mem/wb forwarding
	task automatic rtype_chain();
		word_t v1, v2, v3, v4, v5, v6, v7;
		v1 = 32'h0000_1234;
		v2 = 32'h0000_0f0f;
		v3 = v1 + v2;
		v4 = v3 - v1;
		v5 = v4 & v3;
		v6 = v5 | v1;
		v7 = ~(v6 | v4);
		prog_q = '{encode_itype(op_ori, 1, 0, 'h1234), encode_itype(op_ori, 2, 0, 'h0f0f),
			encode_rtype(fn_add, 3, 1, 2), encode_rtype(fn_sub, 4, 3, 1),
			encode_rtype(fn_and, 5, 4, 3), encode_rtype(fn_or, 6, 5, 1),
			encode_rtype(fn_nor, 7, 6, 4)};
		expect_wb(1, v1);
		expect_wb(2, v2);
		expect_wb(3, v3);
		expect_wb(4, v4);
		expect_wb(5, v5);
		expect_wb(6, v6);
		expect_wb(7, v7);
		run_program("rtype chain");
	endtask

	task automatic immediate_extension();
		prog_q = '{encode_itype(op_addi, 8, 0, -5),
			encode_itype(op_ori, 9, 0, 'h8001),   // bit 15 set but zero extended
			encode_itype(op_addi, 10, 9, -1)};
		expect_wb(8, word_t'(-5));
		expect_wb(9, 32'h0000_8001);
		expect_wb(10, 32'h0000_8001 + word_t'(-1));
		run_program("immediates");
	endtask

	task automatic store_then_load();
		prog_q = '{encode_itype(op_ori, 11, 0, 'hbeef), encode_itype(op_addi, 12, 0, 'h40),
			encode_itype(op_sw, 11, 12, 8),      // mem[0x48]
			encode_itype(op_lw, 13, 12, 8),
			32'h0,                              // load-use gap
			encode_rtype(fn_add, 14, 13, 11),
			encode_itype(op_addi, 15, 0, -1),
			encode_itype(op_sw, 15, 12, 4),      // mem[0x44] with forwarded store data
			encode_itype(op_lw, 16, 12, 8),
			encode_itype(op_lw, 17, 12, 4)};
		expect_wb(11, 32'h0000_beef);
		expect_wb(12, 32'h0000_0040);
		expect_wb(13, 32'h0000_beef);
		expect_wb(14, 32'h0000_beef + 32'h0000_beef);
		expect_wb(15, 32'hffff_ffff);
		expect_wb(16, 32'h0000_beef);
		expect_wb(17, 32'hffff_ffff);
		run_program("store load");
	endtask

	// beq taken to word 8 then bne falls through
	task automatic branch_delay_slots();
		prog_q = '{encode_itype(op_ori, 1, 0, 7), encode_itype(op_ori, 2, 0, 7),
			encode_itype(op_beq, 2, 1, 5),
			encode_itype(op_addi, 3, 0, 1), encode_itype(op_addi, 4, 0, 2),
			encode_itype(op_addi, 5, 0, 3),
			encode_itype(op_addi, 6, 0, 'h66), encode_itype(op_addi, 7, 0, 'h77),   // skipped
			encode_itype(op_bne, 2, 1, 6),
			encode_itype(op_addi, 16, 0, 'h10), encode_itype(op_addi, 17, 0, 'h11),
			encode_itype(op_addi, 18, 0, 'h12), encode_itype(op_addi, 19, 0, 'h13)};
		expect_wb(1, 32'd7);
		expect_wb(2, 32'd7);
		expect_wb(3, 32'd1);    // three delay slots
		expect_wb(4, 32'd2);
		expect_wb(5, 32'd3);
		expect_wb(16, 32'h10);
		expect_wb(17, 32'h11);
		expect_wb(18, 32'h12);
		expect_wb(19, 32'h13);  // not taken path
		run_program("branches");
	endtask

	task automatic r0_and_random_ops();
		word_t             rnd;
		word_t             a;
		word_t             b;
		word_t             sc;
		logic signed [15:0] c;
		rnd = $random(seed);
		a   = {16'h0, rnd[15:0]};
		rnd = $random(seed);
		b   = {16'h0, rnd[15:0]};
		rnd = $random(seed);
		c   = rnd[15:0];
		sc  = word_t'(c);
		prog_q = '{encode_itype(op_ori, 20, 0, int'(a[15:0])),
			encode_itype(op_ori, 21, 0, int'(b[15:0])),
			encode_rtype(fn_add, 0, 20, 21),     // r0 target
			encode_rtype(fn_add, 22, 0, 20),
			encode_rtype(fn_add, 23, 20, 21), encode_rtype(fn_sub, 24, 20, 21),
			encode_itype(op_addi, 25, 0, int'(c)),
			encode_rtype(fn_sub, 26, 25, 20),
			encode_rtype(fn_add, 27, 0, 21)};    // r0 read after its write-back
		expect_wb(20, a);
		expect_wb(21, b);
		expect_wb(0, a + b);
		expect_wb(22, a);
		expect_wb(23, a + b);
		expect_wb(24, a - b);
		expect_wb(25, sc);
		expect_wb(26, sc - a);
		expect_wb(27, b);
		run_program("r0 and random");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, run still busy after %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		reset_i     = 1'b1;
		imem_we_i   = 1'b0;
		imem_addr_i = '0;
		imem_data_i = '0;
		rtype_chain();
		immediate_extension();
		store_then_load();
		branch_delay_slots();
		r0_and_random_ops();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4;   // 8 ns period

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

endmodule
